// File: Makefile
VERILATOR  = verilator
TOP        = lsu_subsystem_tb
FILELIST   = lsu_subsystem.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
PASS_MSG   = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: lsu_subsystem.f
verilog/lsu_pkg.sv
verilog/lsu_store_align.sv
verilog/lsu_load_align.sv
verilog/lsu_axi_master.sv
verilog/axi_sram.sv
verilog/lsu_subsystem.sv
verif/lsu_subsystem_checker.sv
verif/lsu_subsystem_tb.sv

// File: verif/lsu_subsystem_checker.sv
module lsu_subsystem_checker (
  input logic clk,
  input logic rst,
  input logic req_valid,
  input logic req_ready,
  input logic resp_valid,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic bvalid,
  input logic bready,
  input logic arvalid,
  input logic arready,
  input logic rvalid,
  input logic rready
);

  timeunit 1ns;
  timeprecision 1ps;

  // A valid that has not met its ready must still be there a cycle later
  aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");
  w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before wready");
  b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");
  ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");
  r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  resp_single: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
    else $error("resp_valid high for two cycles in a row");

  // req_ready falls after acceptance and comes back only with the response
  ready_falls: assert property (@(posedge clk) disable iff (rst) req_valid && req_ready |=> !req_ready)
    else $error("req_ready still high after acceptance");
  ready_rises: assert property (@(posedge clk) disable iff (rst) $rose(req_ready) |-> resp_valid)
    else $error("req_ready rose without a response");
  resp_ready: assert property (@(posedge clk) disable iff (rst) resp_valid |-> req_ready)
    else $error("resp_valid without req_ready");

endmodule

bind lsu_subsystem lsu_subsystem_checker protocol_check (
  .clk        (clk),
  .rst        (rst),
  .req_valid  (req_valid),
  .req_ready  (req_ready),
  .resp_valid (resp_valid),
  .awvalid    (awvalid),
  .awready    (awready),
  .wvalid     (wvalid),
  .wready     (wready),
  .bvalid     (bvalid),
  .bready     (bready),
  .arvalid    (arvalid),
  .arready    (arready),
  .rvalid     (rvalid),
  .rready     (rready)
);

// File: verif/lsu_subsystem_tb.sv
module lsu_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MEM_BYTES  = lsu_pkg::MEM_WORDS * 8;
  localparam int          WAIT_LIMIT = 100;
  localparam int          RANDOM_OPS = 300;

  localparam logic [2:0] F3_B  = {1'b0, lsu_pkg::SIZE_BYTE};
  localparam logic [2:0] F3_H  = {1'b0, lsu_pkg::SIZE_HALF};
  localparam logic [2:0] F3_W  = {1'b0, lsu_pkg::SIZE_WORD};
  localparam logic [2:0] F3_BU = {1'b1, lsu_pkg::SIZE_BYTE};
  localparam logic [2:0] F3_HU = {1'b1, lsu_pkg::SIZE_HALF};

  logic                       clk;
  logic                       rst;
  logic                       req_valid;
  logic                       req_ready;
  logic                       req_we;
  logic [lsu_pkg::ADDR_W-1:0] req_addr;
  logic [lsu_pkg::XLEN-1:0]   req_wdata;
  lsu_pkg::mem_funct3_u       req_funct3;
  logic                       resp_valid;
  logic [lsu_pkg::XLEN-1:0]   resp_rdata;
  logic                       resp_err;

  // Byte-wide copy of the SRAM, updated as stores are issued
  logic [7:0]  model_mem [MEM_BYTES];
  logic [31:0] exp_data_q [$];
  logic        exp_err_q [$];
  logic        exp_load_q [$];
  logic [31:0] exp_addr_q [$];

  int data_errors  = 0;
  int resp_errors  = 0;
  int other_errors = 0;
  int timeouts     = 0;

  lsu_subsystem dut (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_we     (req_we),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_funct3 (req_funct3),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    fill_word = (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  // Returns {error, data} for a load, with bit 2 of funct3 selecting zero extension
  function automatic logic [32:0] ref_load(input logic [31:0] addr, input logic [2:0] funct3);
    int          idx;
    logic        ext;
    logic [31:0] value;
    if (addr >= MEM_BYTES) begin
      return {1'b1, 32'h0};
    end
    idx = int'(addr);
    case (funct3[1:0])
      2'd0: begin
        ext   = model_mem[idx][7] & ~funct3[2];
        value = {{24{ext}}, model_mem[idx]};
      end
      2'd1: begin
        ext   = model_mem[idx+1][7] & ~funct3[2];
        value = {{16{ext}}, model_mem[idx+1], model_mem[idx]};
      end
      default: begin
        value = {model_mem[idx+3], model_mem[idx+2], model_mem[idx+1], model_mem[idx]};
      end
    endcase
    return {1'b0, value};
  endfunction

  function automatic void model_store(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [2:0] funct3);
    int bytes;
    if (addr >= MEM_BYTES) begin
      return;
    end
    bytes = (funct3[1:0] == 2'd0) ? 1 : (funct3[1:0] == 2'd1) ? 2 : 4;
    for (int i = 0; i < bytes; i++) begin
      model_mem[int'(addr) + i] = data[i*8 +: 8];
    end
  endfunction

  task automatic finish_run();
    $display("Errors: resp_rdata %0d, resp_err %0d, other %0d, timeouts %0d",
             data_errors, resp_errors, other_errors, timeouts);
    if (data_errors + resp_errors + other_errors + timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // Called just after a falling edge; leaves the bus idle one falling edge later
  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [2:0] funct3);
    logic [32:0] expected;
    int          waited;
    waited = 0;
    while (req_ready !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout: req_ready stayed low for %0d cycles", WAIT_LIMIT);
        timeouts++;
        finish_run();
      end
    end
    req_valid      = 1'b1;
    req_we         = we;
    req_addr       = addr;
    req_wdata      = wdata;
    req_funct3.raw = funct3;
    if (we) begin
      model_store(addr, wdata, funct3);
      exp_data_q.push_back(32'h0);
      exp_err_q.push_back(addr >= MEM_BYTES);
      exp_load_q.push_back(1'b0);
    end else begin
      expected = ref_load(addr, funct3);
      exp_data_q.push_back(expected[31:0]);
      exp_err_q.push_back(expected[32]);
      exp_load_q.push_back(1'b1);
    end
    exp_addr_q.push_back(addr);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout: %0d responses never arrived", exp_data_q.size());
        timeouts++;
        finish_run();
      end
    end
  endtask

  always @(negedge clk) begin : compare
    logic [31:0] e_data;
    logic        e_err;
    logic        e_load;
    logic [31:0] e_addr;
    if (!rst && resp_valid === 1'b1) begin
      assert (exp_data_q.size() != 0) else begin
        $display("Response pulse arrived with no request in flight");
        other_errors++;
      end
      if (exp_data_q.size() != 0) begin
        e_data = exp_data_q.pop_front();
        e_err  = exp_err_q.pop_front();
        e_load = exp_load_q.pop_front();
        e_addr = exp_addr_q.pop_front();
        assert (resp_err === e_err) else begin
          $display("Fail resp_err at addr %h: got %h expected %h", e_addr, resp_err, e_err);
          resp_errors++;
        end
        if (e_load) begin
          assert (resp_rdata === e_data) else begin
            $display("Fail resp_rdata at addr %h: got %h expected %h",
                     e_addr, resp_rdata, e_data);
            data_errors++;
          end
        end
      end
    end
  end

  initial begin
    int unsigned word;
    logic [31:0] addr;
    logic [1:0]  size;
    logic        uns;
    logic        we;
    void'($urandom(73621));
    clk        = 1'b0;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    req_funct3 = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    repeat (4) begin
      @(negedge clk);
      assert (req_ready === 1'b1) else begin
        $display("Fail req_ready after reset: got %h expected %h", req_ready, 1'b1);
        other_errors++;
      end
      assert (resp_valid === 1'b0) else begin
        $display("Fail resp_valid before any request: got %h expected %h", resp_valid, 1'b0);
        other_errors++;
      end
    end

    // The SRAM powers up unknown, so every byte gets a defined value first
    for (int unsigned a = 0; a < MEM_BYTES; a += 4) begin
      issue(1'b1, 32'(a), fill_word(32'(a)), F3_W);
    end

    issue(1'b1, 32'h0000_0100, 32'hDEAD_BEEF, F3_W);
    issue(1'b0, 32'h0000_0100, 32'h0, F3_W);
    issue(1'b0, 32'h0000_0104, 32'h0, F3_W);

    for (int off = 0; off < 8; off++) begin
      issue(1'b1, 32'h0000_02A0 + off, $urandom, F3_B);
      issue(1'b0, 32'h0000_02A0, 32'h0, F3_W);
      issue(1'b0, 32'h0000_02A4, 32'h0, F3_W);
    end
    for (int off = 0; off < 8; off += 2) begin
      issue(1'b1, 32'h0000_02B0 + off, $urandom, F3_H);
      issue(1'b0, 32'h0000_02B0, 32'h0, F3_W);
      issue(1'b0, 32'h0000_02B4, 32'h0, F3_W);
    end

    // Every half here has bit 15 unlike bit 7, and the bytes carry both signs
    issue(1'b1, 32'h0000_03C0, 32'h807F_01FF, F3_W);
    issue(1'b1, 32'h0000_03C4, 32'h7F80_FF01, F3_W);
    for (int off = 0; off < 8; off++) begin
      issue(1'b0, 32'h0000_03C0 + off, 32'h0, F3_B);
      issue(1'b0, 32'h0000_03C0 + off, 32'h0, F3_BU);
    end
    for (int off = 0; off < 8; off += 2) begin
      issue(1'b0, 32'h0000_03C0 + off, 32'h0, F3_H);
      issue(1'b0, 32'h0000_03C0 + off, 32'h0, F3_HU);
    end

    issue(1'b1, MEM_BYTES, 32'h1234_5678, F3_W);
    issue(1'b0, MEM_BYTES, 32'h0, F3_W);
    issue(1'b1, 32'hFFFF_FFF8, 32'h0000_00AA, F3_B);
    issue(1'b0, 32'h0000_1004, 32'h0, F3_H);
    issue(1'b0, 32'h0000_0000, 32'h0, F3_W);
    issue(1'b0, 32'h0000_0004, 32'h0, F3_W);
    issue(1'b0, 32'h0000_07F8, 32'h0, F3_W);

    for (int n = 0; n < RANDOM_OPS; n++) begin
      we   = 1'($urandom_range(0, 1));
      size = 2'($urandom_range(0, 2));
      uns  = (!we && size != 2'd2) ? 1'($urandom_range(0, 1)) : 1'b0;
      word = $urandom_range(0, lsu_pkg::MEM_WORDS - 1);
      if ($urandom_range(0, 19) == 0) begin
        word = word + lsu_pkg::MEM_WORDS;
      end
      addr = 32'(word * 8 + $urandom_range(0, 7));
      if (size == 2'd1) begin
        addr[0] = 1'b0;
      end else if (size == 2'd2) begin
        addr[1:0] = 2'b00;
      end
      issue(we, addr, $urandom, {uns, size});
    end

    drain();
    finish_run();
  end

endmodule

// File: verilog/axi_sram.sv
module axi_sram (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           awvalid,
  output logic                           awready,
  input  logic [lsu_pkg::ADDR_W-1:0]     awaddr,
  input  logic [2:0]                     awsize,
  input  logic [lsu_pkg::AXI_ID_W-1:0]   awid,
  input  logic [7:0]                     awlen,
  input  logic [1:0]                     awburst,

  input  logic                           wvalid,
  output logic                           wready,
  input  logic [lsu_pkg::AXI_DATA_W-1:0] wdata,
  input  logic [lsu_pkg::AXI_STRB_W-1:0] wstrb,
  input  logic                           wlast,

  output logic                           bvalid,
  input  logic                           bready,
  output logic [1:0]                     bresp,

  input  logic                           arvalid,
  output logic                           arready,
  input  logic [lsu_pkg::ADDR_W-1:0]     araddr,
  input  logic [2:0]                     arsize,
  input  logic [lsu_pkg::AXI_ID_W-1:0]   arid,
  input  logic [7:0]                     arlen,
  input  logic [1:0]                     arburst,

  output logic                           rvalid,
  input  logic                           rready,
  output logic [lsu_pkg::AXI_DATA_W-1:0] rdata,
  output logic [1:0]                     rresp,
  output logic                           rlast
);

  logic [lsu_pkg::AXI_DATA_W-1:0] mem [lsu_pkg::MEM_WORDS];

  logic                           aw_full;
  logic                           aw_ok_q;
  logic [lsu_pkg::MEM_ADDR_W-1:0] aw_idx_q;
  logic                           w_full;
  logic [lsu_pkg::AXI_DATA_W-1:0] w_data_q;
  logic [lsu_pkg::AXI_STRB_W-1:0] w_strb_q;
  logic                           w_last_q;
  logic                           commit;

  // Only in-range single beats on the fixed ID are served, all else is DECERR
  function automatic logic access_ok(input logic [lsu_pkg::ADDR_W-1:0]   addr,
                                     input logic [2:0]                   size,
                                     input logic [lsu_pkg::AXI_ID_W-1:0] id,
                                     input logic [7:0]                   len,
                                     input logic [1:0]                   burst);
    logic in_range;
    in_range  = addr[lsu_pkg::ADDR_W-1:3] < lsu_pkg::MEM_WORDS;
    access_ok = in_range && size <= $clog2(lsu_pkg::AXI_STRB_W) && id == lsu_pkg::AXI_ID &&
                len == 8'd0 && burst == lsu_pkg::AXI_BURST_INCR;
  endfunction

  assign arready = ~rvalid;
  assign rlast   = 1'b1;
  assign awready = ~aw_full;
  assign wready  = ~w_full;
  assign commit  = aw_full & w_full & ~bvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      if (access_ok(araddr, arsize, arid, arlen, arburst)) begin
        rdata <= mem[araddr[3 +: lsu_pkg::MEM_ADDR_W]];
        rresp <= lsu_pkg::AXI_RESP_OKAY;
      end else begin
        rdata <= '0;
        rresp <= lsu_pkg::AXI_RESP_DECERR;
      end
    end
  end

  // AW and W wait in their own slots, so either may arrive first
  always_ff @(posedge clk) begin
    if (rst) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        aw_full <= 1'b1;
      end
      if (wvalid && wready) begin
        w_full <= 1'b1;
      end
      if (commit) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
        bvalid  <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      aw_ok_q  <= access_ok(awaddr, awsize, awid, awlen, awburst);
      aw_idx_q <= awaddr[3 +: lsu_pkg::MEM_ADDR_W];
    end
    if (wvalid && wready) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
      w_last_q <= wlast;
    end
    if (commit) begin
      bresp <= (aw_ok_q && w_last_q) ? lsu_pkg::AXI_RESP_OKAY : lsu_pkg::AXI_RESP_DECERR;
      if (aw_ok_q && w_last_q) begin
        for (int i = 0; i < lsu_pkg::AXI_STRB_W; i++) begin
          if (w_strb_q[i]) begin
            mem[aw_idx_q][i*8 +: 8] <= w_data_q[i*8 +: 8];
          end
        end
      end
    end
  end

endmodule

// File: verilog/lsu_axi_master.sv
module lsu_axi_master (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           req_valid,
  output logic                           req_ready,
  input  logic                           req_we,
  input  logic [lsu_pkg::ADDR_W-1:0]     req_addr,
  input  logic [lsu_pkg::XLEN-1:0]       req_wdata,
  input  lsu_pkg::mem_funct3_u           req_funct3,
  output logic                           resp_valid,
  output logic [lsu_pkg::XLEN-1:0]       resp_rdata,
  output logic                           resp_err,

  output logic                           awvalid,
  input  logic                           awready,
  output logic [lsu_pkg::ADDR_W-1:0]     awaddr,
  output logic [2:0]                     awsize,
  output logic [lsu_pkg::AXI_ID_W-1:0]   awid,
  output logic [7:0]                     awlen,
  output logic [1:0]                     awburst,

  output logic                           wvalid,
  input  logic                           wready,
  output logic [lsu_pkg::AXI_DATA_W-1:0] wdata,
  output logic [lsu_pkg::AXI_STRB_W-1:0] wstrb,
  output logic                           wlast,

  input  logic                           bvalid,
  output logic                           bready,
  input  logic [1:0]                     bresp,

  output logic                           arvalid,
  input  logic                           arready,
  output logic [lsu_pkg::ADDR_W-1:0]     araddr,
  output logic [2:0]                     arsize,
  output logic [lsu_pkg::AXI_ID_W-1:0]   arid,
  output logic [7:0]                     arlen,
  output logic [1:0]                     arburst,

  input  logic                           rvalid,
  output logic                           rready,
  input  logic [lsu_pkg::AXI_DATA_W-1:0] rdata,
  input  logic [1:0]                     rresp,
  input  logic                           rlast
);

  logic                           accept;
  logic                           rd_busy;
  logic                           ar_done;
  logic                           wr_busy;
  logic                           aw_done;
  logic                           w_done;
  logic [lsu_pkg::ADDR_W-1:0]     addr_q;
  lsu_pkg::mem_funct3_u           funct3_q;
  logic [lsu_pkg::AXI_DATA_W-1:0] lane_data;
  logic [lsu_pkg::AXI_STRB_W-1:0] lane_strb;
  logic [lsu_pkg::AXI_DATA_W-1:0] wdata_q;
  logic [lsu_pkg::AXI_STRB_W-1:0] wstrb_q;
  logic [lsu_pkg::XLEN-1:0]       load_data;

  assign accept = req_valid & req_ready;

  lsu_store_align u_store_align (
    .addr      (req_addr),
    .funct3    (req_funct3),
    .wdata     (req_wdata),
    .lane_data (lane_data),
    .lane_strb (lane_strb)
  );

  lsu_load_align u_load_align (
    .addr   (addr_q),
    .funct3 (funct3_q),
    .beat   (rdata),
    .data   (load_data)
  );

  // Each valid drops on its own handshake through the done flags
  assign arvalid = rd_busy & ~ar_done;
  assign rready  = rd_busy;
  assign awvalid = wr_busy & ~aw_done;
  assign wvalid  = wr_busy & ~w_done;
  assign bready  = wr_busy & aw_done & w_done;

  assign araddr  = addr_q;
  assign arsize  = {1'b0, funct3_q.f.size};
  assign arid    = lsu_pkg::AXI_ID;
  assign arlen   = 8'd0;
  assign arburst = lsu_pkg::AXI_BURST_INCR;
  assign awaddr  = addr_q;
  assign awsize  = {1'b0, funct3_q.f.size};
  assign awid    = lsu_pkg::AXI_ID;
  assign awlen   = 8'd0;
  assign awburst = lsu_pkg::AXI_BURST_INCR;
  assign wdata   = wdata_q;
  assign wstrb   = wstrb_q;
  assign wlast   = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_ready  <= 1'b1;
      resp_valid <= 1'b0;
      resp_err   <= 1'b0;
      rd_busy    <= 1'b0;
      ar_done    <= 1'b0;
      wr_busy    <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      if (accept) begin
        req_ready <= 1'b0;
        rd_busy   <= ~req_we;
        wr_busy   <= req_we;
        ar_done   <= 1'b0;
        aw_done   <= 1'b0;
        w_done    <= 1'b0;
      end
      if (arvalid && arready) begin
        ar_done <= 1'b1;
      end
      if (rvalid && rready && rlast) begin
        rd_busy    <= 1'b0;
        resp_valid <= 1'b1;
        resp_err   <= rresp != lsu_pkg::AXI_RESP_OKAY;
        req_ready  <= 1'b1;
      end
      if (awvalid && awready) begin
        aw_done <= 1'b1;
      end
      if (wvalid && wready) begin
        w_done <= 1'b1;
      end
      if (bvalid && bready) begin
        wr_busy    <= 1'b0;
        resp_valid <= 1'b1;
        resp_err   <= bresp != lsu_pkg::AXI_RESP_OKAY;
        req_ready  <= 1'b1;
      end
    end
  end

  // Store lanes are formed from the request itself and held for the W channel
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q   <= req_addr;
      funct3_q <= req_funct3;
      wdata_q  <= lane_data;
      wstrb_q  <= lane_strb;
    end
    if (rvalid && rready) begin
      resp_rdata <= load_data;
    end
  end

endmodule

// File: verilog/lsu_load_align.sv
module lsu_load_align (
  input  logic [lsu_pkg::ADDR_W-1:0]     addr,
  input  lsu_pkg::mem_funct3_u           funct3,
  input  logic [lsu_pkg::AXI_DATA_W-1:0] beat,
  output logic [lsu_pkg::XLEN-1:0]       data
);

  logic [lsu_pkg::XLEN-1:0] word_sel;
  logic [7:0]               byte_sel;
  logic [15:0]              half_sel;
  logic                     byte_sign;
  logic                     half_sign;

  always_comb begin
    // Address bit 2 picks the upper or lower word of the beat
    word_sel  = addr[2] ? beat[lsu_pkg::XLEN +: lsu_pkg::XLEN] : beat[lsu_pkg::XLEN-1:0];
    byte_sel  = word_sel[{addr[1:0], 3'b000} +: 8];
    half_sel  = word_sel[{addr[1], 4'b0000} +: 16];
    byte_sign = byte_sel[7] & ~funct3.f.is_unsigned;
    half_sign = half_sel[15] & ~funct3.f.is_unsigned;

    case (funct3.f.size)
      lsu_pkg::SIZE_BYTE: data = {{(lsu_pkg::XLEN - 8){byte_sign}}, byte_sel};
      lsu_pkg::SIZE_HALF: data = {{(lsu_pkg::XLEN - 16){half_sign}}, half_sel};
      default:            data = word_sel;
    endcase
  end

endmodule

// File: verilog/lsu_pkg.sv
package lsu_pkg;

  localparam int ADDR_W     = 32;
  localparam int XLEN       = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_ID_W   = 4;

  localparam logic [1:0]          AXI_RESP_OKAY   = 2'd0;
  localparam logic [1:0]          AXI_RESP_DECERR = 2'd3;
  localparam logic [1:0]          AXI_BURST_INCR  = 2'd1;
  localparam logic [AXI_ID_W-1:0] AXI_ID          = '0;

  // Shared by the AXI size field and the low two funct3 bits
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // SRAM depth in bus words
  localparam int MEM_WORDS  = 256;
  localparam int MEM_ADDR_W = 8;

  typedef struct packed {
    logic       is_unsigned;
    logic [1:0] size;
  } mem_funct3_fields_t;

  // RV32 load/store funct3, either as the raw code or split into fields
  typedef union packed {
    logic [2:0]         raw;
    mem_funct3_fields_t f;
  } mem_funct3_u;

endpackage

// File: verilog/lsu_store_align.sv
module lsu_store_align (
  input  logic [lsu_pkg::ADDR_W-1:0]     addr,
  input  lsu_pkg::mem_funct3_u           funct3,
  input  logic [lsu_pkg::XLEN-1:0]       wdata,
  output logic [lsu_pkg::AXI_DATA_W-1:0] lane_data,
  output logic [lsu_pkg::AXI_STRB_W-1:0] lane_strb
);

  logic [lsu_pkg::AXI_STRB_W-1:0] strb_base;

  // The value is repeated on every lane, so only the strobe has to move
  always_comb begin
    case (funct3.f.size)
      lsu_pkg::SIZE_BYTE: begin
        lane_data = {(lsu_pkg::AXI_DATA_W / 8){wdata[7:0]}};
        strb_base = lsu_pkg::AXI_STRB_W'(1);
      end
      lsu_pkg::SIZE_HALF: begin
        lane_data = {(lsu_pkg::AXI_DATA_W / 16){wdata[15:0]}};
        strb_base = lsu_pkg::AXI_STRB_W'(3);
      end
      default: begin
        lane_data = {(lsu_pkg::AXI_DATA_W / lsu_pkg::XLEN){wdata}};
        strb_base = lsu_pkg::AXI_STRB_W'(15);
      end
    endcase
    lane_strb = strb_base << addr[2:0];
  end

endmodule

// File: verilog/lsu_subsystem.sv
module lsu_subsystem (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  logic                       req_we,
  input  logic [lsu_pkg::ADDR_W-1:0] req_addr,
  input  logic [lsu_pkg::XLEN-1:0]   req_wdata,
  input  lsu_pkg::mem_funct3_u       req_funct3,
  output logic                       resp_valid,
  output logic [lsu_pkg::XLEN-1:0]   resp_rdata,
  output logic                       resp_err
);

  logic                           awvalid;
  logic                           awready;
  logic [lsu_pkg::ADDR_W-1:0]     awaddr;
  logic [2:0]                     awsize;
  logic [lsu_pkg::AXI_ID_W-1:0]   awid;
  logic [7:0]                     awlen;
  logic [1:0]                     awburst;
  logic                           wvalid;
  logic                           wready;
  logic [lsu_pkg::AXI_DATA_W-1:0] wdata;
  logic [lsu_pkg::AXI_STRB_W-1:0] wstrb;
  logic                           wlast;
  logic                           bvalid;
  logic                           bready;
  logic [1:0]                     bresp;
  logic                           arvalid;
  logic                           arready;
  logic [lsu_pkg::ADDR_W-1:0]     araddr;
  logic [2:0]                     arsize;
  logic [lsu_pkg::AXI_ID_W-1:0]   arid;
  logic [7:0]                     arlen;
  logic [1:0]                     arburst;
  logic                           rvalid;
  logic                           rready;
  logic [lsu_pkg::AXI_DATA_W-1:0] rdata;
  logic [1:0]                     rresp;
  logic                           rlast;

  lsu_axi_master lsu (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_we     (req_we),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_funct3 (req_funct3),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .awsize     (awsize),
    .awid       (awid),
    .awlen      (awlen),
    .awburst    (awburst),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .arsize     (arsize),
    .arid       (arid),
    .arlen      (arlen),
    .arburst    (arburst),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rlast      (rlast)
  );

  axi_sram sram (
    .clk     (clk),
    .rst     (rst),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awsize  (awsize),
    .awid    (awid),
    .awlen   (awlen),
    .awburst (awburst),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arsize  (arsize),
    .arid    (arid),
    .arlen   (arlen),
    .arburst (arburst),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast)
  );

endmodule
